/* source/smpc_params.svh */
`ifndef SMPC_PARAMS_SVH
`define SMPC_PARAMS_SVH

`define SMPC_SEC_DIV            4000000

`define SMPC_WAIT_W             10
`define SMPC_WAIT_CMD_SHORT     60
`define SMPC_WAIT_CMD           60
`define SMPC_WAIT_CMD_CD        100
`define SMPC_WAIT_NMI           70
`define SMPC_WAIT_SETTIME       220
`define SMPC_WAIT_INTBACK       800
`define SMPC_SRES_HOLD          60000

`define SMPC_ADDR_IREG0         7'h01
`define SMPC_ADDR_COMREG        7'h1F
`define SMPC_ADDR_OREG0         7'h21
`define SMPC_ADDR_OREG_LAST     7'h5F
`define SMPC_ADDR_SR            7'h61
`define SMPC_ADDR_SF            7'h63

`define SMPC_OREG_WORDS         32
`define SMPC_OREG_AW            5

`define SMPC_INTBACK_STATUS_KEY 8'hF0
`define SMPC_IREG0_STATUS_BIT   0
`define SMPC_SR_SRES_BIT        4
`define SMPC_SR_INTBACK_END     8'h4F

`define SMPC_RTC_RESET_YEAR     16'h2024
`define SMPC_RTC_RESET_WDAY     4'd1
`define SMPC_RTC_RESET_MONTH    4'd1
`define SMPC_RTC_RESET_MDAY     8'h01

`endif

/* source/smpc_pkg.sv */
package smpc_pkg;

	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_INTBACK = 8'h10,
		CMD_SETTIME = 8'h16,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} smpc_cmd_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT,
		ST_COMMAND,
		ST_EXEC,
		ST_END
	} smpc_state_e;

	typedef struct packed {
		logic [15:0] year;   // Binary coded as BCD digits by software
		logic [3:0]  wday;
		logic [3:0]  month;  // Binary 1..12
		logic [7:0]  mday;
		logic [7:0]  hour;
		logic [7:0]  min;
		logic [7:0]  sec;
	} smpc_time_t;

	typedef union packed {
		smpc_time_t           t;
		logic [0:6][7:0]      b;  // b[0] year high, b[6] seconds
	} smpc_time_u;

endpackage

/* source/smpc_host_regs.sv */
`include "smpc_params.svh"

module smpc_host_regs (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic [5:0]           a,
	input  logic [7:0]           di,
	input  logic                 cs_n,
	input  logic                 rw_n,
	output smpc_pkg::smpc_time_u ireg,
	output smpc_pkg::smpc_cmd_e  comreg,
	output logic                 comreg_set,
	output logic                 sf_set
);
	import smpc_pkg::*;

	logic       rw_n_old;
	logic       wr_stb;
	logic [6:0] addr;
	logic [6:0] ireg_off;
	logic       ireg_hit;

	assign addr = {a, 1'b1};  // Odd byte address
	assign wr_stb = !rw_n && rw_n_old && !cs_n;  // First cycle of a write
	assign ireg_off = addr - `SMPC_ADDR_IREG0;
	assign ireg_hit = ireg_off[6:1] < 6'd7;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			comreg_set <= 1'b0;
			sf_set <= 1'b0;
		end else begin
			rw_n_old <= rw_n;
			comreg_set <= wr_stb && addr == `SMPC_ADDR_COMREG;
			sf_set <= wr_stb && addr == `SMPC_ADDR_SF && di[0];  // Only a 1 sets SF
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_stb && ireg_hit) begin
			ireg.b[ireg_off[3:1]] <= di;
		end
		if (wr_stb && addr == `SMPC_ADDR_COMREG) begin
			comreg <= smpc_cmd_e'(di);  // Unknown codes kept as written
		end
	end

endmodule

/* source/smpc_cmd_exec.sv */
`include "smpc_params.svh"

module smpc_cmd_exec (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic                     ce,
	input  logic                     mres_n,
	input  logic                     time_set,
	input  logic                     sres_n,
	input  logic [3:0]               ac,
	input  smpc_pkg::smpc_time_u     ireg,
	input  smpc_pkg::smpc_cmd_e      comreg,
	input  logic                     comreg_set,
	input  logic                     sf_set,
	input  smpc_pkg::smpc_time_u     time_now,
	output logic [7:0]               sr,
	output logic                     sf,
	output logic                     oreg_we,
	output logic [`SMPC_OREG_AW-1:0] oreg_waddr,
	output logic [7:0]               oreg_wdata,
	output logic                     time_load,
	output logic                     mshres_n,
	output logic                     mshnmi_n,
	output logic                     sshres_n,
	output logic                     sshnmi_n,
	output logic                     sysres_n,
	output logic                     sndres_n,
	output logic                     cdres_n,
	output logic                     mirq_n
);
	import smpc_pkg::*;

	localparam int OREG_LAST = `SMPC_OREG_WORDS - 1;
	localparam int SRES_HOLD = `SMPC_SRES_HOLD;

	smpc_state_e              state;
	smpc_state_e              next_st;
	smpc_cmd_e                cur_cmd;
	logic [`SMPC_WAIT_W-1:0]  wait_cnt;
	logic [`SMPC_OREG_AW-1:0] oreg_cnt;
	logic [15:0]              sres_cnt;
	logic                     cmd_pend;
	logic                     sres_done;
	logic                     resd;
	logic                     ste;
	logic                     intback_ok;

	function automatic logic [`SMPC_WAIT_W-1:0] wait_load(input int cycles);
		return cycles[`SMPC_WAIT_W-1:0] - 1'b1;
	endfunction

	assign intback_ok = ireg.b[2] == `SMPC_INTBACK_STATUS_KEY &&
		ireg.b[0][`SMPC_IREG0_STATUS_BIT];
	assign time_load = ce && mres_n && state == ST_EXEC && cur_cmd == CMD_SETTIME;

	always_ff @(posedge CLK) begin
		if (ce && mres_n && state == ST_IDLE && cmd_pend) begin
			cur_cmd <= comreg;  // Later writes wait for the next run
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
			next_st <= ST_IDLE;
			wait_cnt <= '0;
			oreg_cnt <= '0;
			sres_cnt <= 16'd0;
			cmd_pend <= 1'b0;
			sres_done <= 1'b0;
			resd <= 1'b1;
			ste <= 1'b0;
			sr <= 8'h00;
			sf <= 1'b0;
			oreg_we <= 1'b0;
			oreg_waddr <= '0;
			oreg_wdata <= 8'h00;
			mshres_n <= 1'b0;
			mshnmi_n <= 1'b0;
			sshres_n <= 1'b0;
			sshnmi_n <= 1'b0;
			sysres_n <= 1'b0;
			sndres_n <= 1'b0;
			cdres_n <= 1'b0;
			mirq_n <= 1'b1;
		end else begin
			oreg_we <= 1'b0;
			if (!mres_n) begin
				mshres_n <= 1'b1;
				mshnmi_n <= 1'b1;
				sshres_n <= 1'b0;
				sshnmi_n <= 1'b1;
				sysres_n <= 1'b1;
				sndres_n <= 1'b0;
				cdres_n <= 1'b1;
				mirq_n <= 1'b1;
				sr <= 8'h00;
				resd <= 1'b1;
				ste <= time_set;
				state <= ST_IDLE;
				sres_done <= 1'b0;  // Re-arm soft reset
				sres_cnt <= 16'd0;
			end else if (ce) begin
				if (wait_cnt != '0) wait_cnt <= wait_cnt - 1'b1;
				if (sres_cnt != 16'd0) sres_cnt <= sres_cnt - 16'd1;

				if (!sres_n && !resd && !sres_done) begin
					mshnmi_n <= 1'b0;
					sshnmi_n <= 1'b0;
					sres_cnt <= SRES_HOLD[15:0];
					sres_done <= 1'b1;
				end else if (sres_cnt == 16'd1) begin
					mshnmi_n <= 1'b1;
					sshnmi_n <= 1'b1;
				end

				case (state)
					ST_IDLE: begin
						mirq_n <= 1'b1;
						if (cmd_pend) begin
							cmd_pend <= 1'b0;
							oreg_cnt <= '0;
							wait_cnt <= wait_load(`SMPC_WAIT_CMD_SHORT);
							next_st <= ST_COMMAND;
							state <= ST_WAIT;
						end
					end
					ST_WAIT: begin
						if (wait_cnt == '0) state <= next_st;
					end
					ST_COMMAND: begin
						next_st <= ST_EXEC;
						state <= ST_WAIT;
						case (cur_cmd)
							CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF:
								wait_cnt <= wait_load(`SMPC_WAIT_CMD);
							CMD_CDON, CMD_CDOFF: wait_cnt <= wait_load(`SMPC_WAIT_CMD_CD);
							CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA:
								wait_cnt <= wait_load(`SMPC_WAIT_NMI);
							CMD_SETTIME: wait_cnt <= wait_load(`SMPC_WAIT_SETTIME);
							CMD_INTBACK: begin
								if (intback_ok) wait_cnt <= wait_load(`SMPC_WAIT_INTBACK);
								else state <= ST_EXEC;  // No peripheral path
							end
							default: state <= ST_EXEC;
						endcase
					end
					ST_EXEC: begin
						oreg_we <= 1'b1;
						oreg_waddr <= OREG_LAST[`SMPC_OREG_AW-1:0];
						oreg_wdata <= cur_cmd;
						state <= ST_END;
						case (cur_cmd)
							CMD_MSHON: begin
								mshres_n <= 1'b1;
								mshnmi_n <= 1'b1;
							end
							CMD_SSHON: begin
								sshres_n <= 1'b1;
								sshnmi_n <= 1'b1;
							end
							CMD_SSHOFF: begin
								sshres_n <= 1'b0;
								sshnmi_n <= 1'b1;
							end
							CMD_SNDON: sndres_n <= 1'b1;
							CMD_SNDOFF: sndres_n <= 1'b0;
							CMD_CDON: cdres_n <= 1'b1;
							CMD_CDOFF: cdres_n <= 1'b0;
							CMD_SETTIME: ste <= 1'b1;
							CMD_NMIREQ: mshnmi_n <= 1'b0;
							CMD_RESENAB: resd <= 1'b0;
							CMD_RESDISA: resd <= 1'b1;
							CMD_INTBACK: begin
								if (intback_ok) begin
									oreg_waddr <= oreg_cnt;
									oreg_cnt <= oreg_cnt + 1'b1;
									case (oreg_cnt)
										5'd0: oreg_wdata <= {ste, resd, 6'b000000};
										5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7:
											oreg_wdata <= time_now.b[oreg_cnt[2:0] - 3'd1];
										5'd9: oreg_wdata <= {4'b0000, ac};
										5'd10: oreg_wdata <= {2'b00, 2'b11, ~mshnmi_n, 1'b1,
											~sysres_n, ~sndres_n};  // Dot select fixed 0
										5'd11: oreg_wdata <= {1'b0, ~cdres_n, 6'b000000};
										5'd31: oreg_wdata <= cur_cmd;
										default: oreg_wdata <= 8'h00;
									endcase
									if (oreg_cnt == OREG_LAST[`SMPC_OREG_AW-1:0]) begin
										sr <= `SMPC_SR_INTBACK_END;
										mirq_n <= 1'b0;
									end else begin
										state <= ST_EXEC;  // One byte per CE
									end
								end
							end
							default: ;
						endcase
					end
					ST_END: begin
						sf <= 1'b0;
						if (cur_cmd == CMD_NMIREQ) mshnmi_n <= 1'b1;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase

				sr[`SMPC_SR_SRES_BIT] <= ~sres_n;  // Reset button level
			end

			// Host writes win over the sequencer on the same edge
			if (comreg_set) cmd_pend <= 1'b1;
			if (comreg_set || sf_set) sf <= 1'b1;
		end
	end

endmodule

/* source/smpc_rtc.sv */
`include "smpc_params.svh"

module smpc_rtc #(
	parameter int SEC_DIV = `SMPC_SEC_DIV
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 time_load,
	input  smpc_pkg::smpc_time_u time_in,
	output smpc_pkg::smpc_time_u time_now
);
	import smpc_pkg::*;

	localparam int DIV_W = $clog2(SEC_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic             sec_tick;
	logic [7:0]       last_mday;
	smpc_time_t       cur;
	smpc_time_t       nxt;

	function automatic logic [7:0] bcd_next(input logic [7:0] v, input logic [7:0] last,
		input logic [7:0] first);
		if (v == last) return first;
		if (v[3:0] == 4'd9) return {v[7:4] + 4'd1, 4'd0};
		return v + 8'd1;
	endfunction

	assign cur = time_now.t;
	assign sec_tick = div_cnt == DIV_W'(SEC_DIV - 1);

	always_comb begin
		case (cur.month)
			4'd2: last_mday = 8'h28;  // No leap years
			4'd4, 4'd6, 4'd9, 4'd11: last_mday = 8'h30;
			default: last_mday = 8'h31;
		endcase
	end

	// Whole carry chain settles in the tick cycle
	always_comb begin
		nxt = cur;
		nxt.sec = bcd_next(cur.sec, 8'h59, 8'h00);
		if (cur.sec == 8'h59) begin
			nxt.min = bcd_next(cur.min, 8'h59, 8'h00);
			if (cur.min == 8'h59) begin
				nxt.hour = bcd_next(cur.hour, 8'h23, 8'h00);
				if (cur.hour == 8'h23) begin
					nxt.mday = bcd_next(cur.mday, last_mday, 8'h01);
					if (cur.mday == last_mday) begin
						nxt.month = (cur.month == 4'd12) ? 4'd1 : cur.month + 4'd1;
						if (cur.month == 4'd12) nxt.year = cur.year + 16'd1;
					end
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			time_now.t <= '{year: `SMPC_RTC_RESET_YEAR, wday: `SMPC_RTC_RESET_WDAY,
				month: `SMPC_RTC_RESET_MONTH, mday: `SMPC_RTC_RESET_MDAY,
				hour: 8'h00, min: 8'h00, sec: 8'h00};
		end else if (ce) begin
			div_cnt <= sec_tick ? '0 : div_cnt + 1'b1;  // Phase not touched by load
			if (time_load) begin
				time_now <= time_in;
			end else if (sec_tick) begin
				time_now.t <= nxt;
			end
		end
	end

endmodule

/* source/smpc_oreg_file.sv */
`include "smpc_params.svh"

module smpc_oreg_file (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic                     oreg_we,
	input  logic [`SMPC_OREG_AW-1:0] oreg_waddr,
	input  logic [7:0]               oreg_wdata,
	input  logic [5:0]               a,
	input  logic                     cs_n,
	input  logic                     rw_n,
	input  logic [7:0]               sr,
	input  logic                     sf,
	output logic [7:0]               do_data
);
	logic [7:0] oreg_mem [`SMPC_OREG_WORDS];
	logic       cs_n_old;
	logic       rd_stb;
	logic [6:0] addr;
	logic [6:0] oreg_off;

	assign addr = {a, 1'b1};
	assign oreg_off = addr - `SMPC_ADDR_OREG0;
	assign rd_stb = !cs_n && cs_n_old && rw_n;  // Chip select just fell on a read

	always_ff @(posedge CLK) begin
		if (oreg_we) oreg_mem[oreg_waddr] <= oreg_wdata;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cs_n_old <= 1'b1;
			do_data <= 8'h00;
		end else begin
			cs_n_old <= cs_n;
			if (rd_stb) begin
				if (addr >= `SMPC_ADDR_OREG0 && addr <= `SMPC_ADDR_OREG_LAST) begin
					do_data <= oreg_mem[oreg_off[`SMPC_OREG_AW:1]];  // Old data on a same-cycle write
				end else if (addr == `SMPC_ADDR_SR) begin
					do_data <= sr;
				end else if (addr == `SMPC_ADDR_SF) begin
					do_data <= {7'b1111000, sf};
				end else begin
					do_data <= 8'h00;
				end
			end
		end
	end

endmodule

/* source/smpc.sv */
`include "smpc_params.svh"

module smpc #(
	parameter int SEC_DIV = `SMPC_SEC_DIV
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       ce,
	input  logic       mres_n,
	input  logic       time_set,
	input  logic [3:0] ac,
	input  logic [5:0] a,
	input  logic [7:0] di,
	input  logic       cs_n,
	input  logic       rw_n,
	input  logic       sres_n,
	output logic [7:0] do_data,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sysres_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n
);
	import smpc_pkg::*;

	smpc_time_u               ireg;
	smpc_time_u               time_now;
	smpc_cmd_e                comreg;
	logic                     comreg_set;
	logic                     sf_set;
	logic [7:0]               sr;
	logic                     sf;
	logic                     oreg_we;
	logic [`SMPC_OREG_AW-1:0] oreg_waddr;
	logic [7:0]               oreg_wdata;
	logic                     time_load;

	smpc_host_regs u_host (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.a          (a),
		.di         (di),
		.cs_n       (cs_n),
		.rw_n       (rw_n),
		.ireg       (ireg),
		.comreg     (comreg),
		.comreg_set (comreg_set),
		.sf_set     (sf_set)
	);

	smpc_cmd_exec u_exec (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.ce         (ce),
		.mres_n     (mres_n),
		.time_set   (time_set),
		.sres_n     (sres_n),
		.ac         (ac),
		.ireg       (ireg),
		.comreg     (comreg),
		.comreg_set (comreg_set),
		.sf_set     (sf_set),
		.time_now   (time_now),
		.sr         (sr),
		.sf         (sf),
		.oreg_we    (oreg_we),
		.oreg_waddr (oreg_waddr),
		.oreg_wdata (oreg_wdata),
		.time_load  (time_load),
		.mshres_n   (mshres_n),
		.mshnmi_n   (mshnmi_n),
		.sshres_n   (sshres_n),
		.sshnmi_n   (sshnmi_n),
		.sysres_n   (sysres_n),
		.sndres_n   (sndres_n),
		.cdres_n    (cdres_n),
		.mirq_n     (mirq_n)
	);

	smpc_rtc #(
		.SEC_DIV (SEC_DIV)
	) u_rtc (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ce        (ce),
		.time_load (time_load),
		.time_in   (ireg),
		.time_now  (time_now)
	);

	smpc_oreg_file u_oreg (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.oreg_we    (oreg_we),
		.oreg_waddr (oreg_waddr),
		.oreg_wdata (oreg_wdata),
		.a          (a),
		.cs_n       (cs_n),
		.rw_n       (rw_n),
		.sr         (sr),
		.sf         (sf),
		.do_data    (do_data)
	);

endmodule

/* dv/smpc_sva.sv */
module smpc_sva (
	input logic                  CLK,
	input logic                  RST_N,
	input smpc_pkg::smpc_state_e state,
	input logic                  sf,
	input logic                  mirq_n,
	input logic                  mres_n,
	input logic                  sshres_n
);
	import smpc_pkg::*;

	// SF only drops on the way out of END
	sf_fall_in_end: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(sf) |-> $past(state) == ST_END)
		else $error("SF fell outside state END");

	mirq_short_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(mirq_n) |-> ##[1:2] mirq_n)
		else $error("MIRQ_N held low too long");

	mres_holds_slave: assert property (@(posedge CLK) disable iff (!RST_N)
		!mres_n |=> !sshres_n)
		else $error("SSHRES_N not low during MRES_N");

endmodule

bind smpc_cmd_exec smpc_sva u_sva (.*);

/* dv/smpc_tb.sv */
`include "smpc_params.svh"

module smpc_tb;
	import smpc_pkg::*;

	localparam int SEC_DIV = 2000;
	localparam int CMD_CYCLES = 2500;  // Worst case INTBACK plus polling
	localparam int N_CMDS = 24;
	localparam int WATCHDOG = (N_CMDS * CMD_CYCLES + 5 * SEC_DIV) * 4;

	logic CLK = 1'b0;
	logic RST_N, ce, mres_n, time_set, cs_n, rw_n, sres_n;
	logic [3:0] ac;
	logic [5:0] a;
	logic [7:0] di, do_data;
	logic mshres_n, mshnmi_n, sshres_n, sshnmi_n, sysres_n, sndres_n, cdres_n, mirq_n;
	int errors = 0;
	int err_mark = 0;
	int seed = 7590;
	logic mirq_seen = 1'b0;
	logic nmi_seen = 1'b0;

	smpc #(.SEC_DIV(SEC_DIV)) u_dut (
		.CLK(CLK), .RST_N(RST_N), .ce(ce), .mres_n(mres_n), .time_set(time_set),
		.ac(ac), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n), .sres_n(sres_n),
		.do_data(do_data), .mshres_n(mshres_n), .mshnmi_n(mshnmi_n), .sshres_n(sshres_n),
		.sshnmi_n(sshnmi_n), .sysres_n(sysres_n), .sndres_n(sndres_n), .cdres_n(cdres_n),
		.mirq_n(mirq_n)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		if (!mirq_n) mirq_seen = 1'b1;
		if (!mshnmi_n) nmi_seen = 1'b1;
	end

	initial begin
		#(WATCHDOG);
		$display("Watchdog expired, a test did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		return (v[3:0] == 4'd9) ? {v[7:4] + 4'd1, 4'd0} : v + 8'd1;
	endfunction

	// Expected clock after a number of whole seconds
	function automatic smpc_time_u ref_advance(input smpc_time_u t, input int secs);
		smpc_time_u r;
		logic [7:0] last;
		r = t;
		for (int i = 0; i < secs; i++) begin
			r.t.sec = bcd_inc(r.t.sec);
			if (r.t.sec == 8'h60) begin
				r.t.sec = 8'h00;
				r.t.min = bcd_inc(r.t.min);
				if (r.t.min == 8'h60) begin
					r.t.min = 8'h00;
					r.t.hour = bcd_inc(r.t.hour);
					if (r.t.hour == 8'h24) begin
						r.t.hour = 8'h00;
						if (r.t.month == 4'd2) last = 8'h28;
						else if (r.t.month inside {4'd4, 4'd6, 4'd9, 4'd11}) last = 8'h30;
						else last = 8'h31;
						if (r.t.mday == last) begin
							r.t.mday = 8'h01;
							if (r.t.month == 4'd12) begin
								r.t.month = 4'd1;
								r.t.year = r.t.year + 16'd1;
							end else begin
								r.t.month = r.t.month + 4'd1;
							end
						end else begin
							r.t.mday = bcd_inc(r.t.mday);
						end
					end
				end
			end
		end
		return r;
	endfunction

	function automatic logic [7:0] rand_bcd(input int base, input int span);
		int v;
		v = base + $unsigned($random(seed)) % span;
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic smpc_time_u rand_time();
		smpc_time_u t;
		t.t.year = {rand_bcd(0, 100), rand_bcd(0, 100)};
		t.t.wday = 4'($unsigned($random(seed)) % 7);
		t.t.month = 4'(1 + $unsigned($random(seed)) % 12);
		t.t.mday = rand_bcd(1, 28);
		t.t.hour = rand_bcd(0, 24);
		t.t.min = rand_bcd(0, 60);
		t.t.sec = rand_bcd(0, 60);
		return t;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_time(input string name, input smpc_time_u exp, input smpc_time_u act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic write_reg(input logic [6:0] addr, input logic [7:0] v);
		@(posedge CLK);
		a <= addr[6:1];
		di <= v;
		cs_n <= 1'b0;
		rw_n <= 1'b0;
		@(posedge CLK);
		cs_n <= 1'b1;
		rw_n <= 1'b1;
	endtask

	task automatic read_reg(input logic [6:0] addr, output logic [7:0] v);
		@(posedge CLK);
		a <= addr[6:1];
		cs_n <= 1'b0;
		rw_n <= 1'b1;
		@(posedge CLK);
		cs_n <= 1'b1;
		@(negedge CLK);
		v = do_data;
	endtask

	task automatic read_oreg(input int n, output logic [7:0] v);
		read_reg(`SMPC_ADDR_OREG0 + 7'(2 * n), v);
	endtask

	task automatic run_cmd(input string name, input logic [7:0] code);
		logic [7:0] v;
		int n;
		write_reg(`SMPC_ADDR_SF, 8'h01);
		write_reg(`SMPC_ADDR_COMREG, code);
		n = 0;
		v = 8'h01;
		while (v[0] && n < 1000) begin
			read_reg(`SMPC_ADDR_SF, v);
			n++;
		end
		if (v[0]) begin
			$display("%s: SF still set after %0d polls", name, n);
			errors++;
		end
	endtask

	task automatic set_time(input smpc_time_u t);
		for (int i = 0; i < 7; i++) write_reg(`SMPC_ADDR_IREG0 + 7'(2 * i), t.b[i]);
		run_cmd("SETTIME", CMD_SETTIME);
	endtask

	task automatic status_intback(output smpc_time_u t, output logic [7:0] o0,
		output logic [7:0] o9);
		logic [7:0] v;
		write_reg(`SMPC_ADDR_IREG0, 8'h01);
		write_reg(`SMPC_ADDR_IREG0 + 7'd4, `SMPC_INTBACK_STATUS_KEY);
		mirq_seen = 1'b0;
		run_cmd("INTBACK", CMD_INTBACK);
		read_oreg(0, o0);
		for (int i = 0; i < 7; i++) begin
			read_oreg(i + 1, v);
			t.b[i] = v;
		end
		read_oreg(9, o9);
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s", name, (errors == err_mark) ? "ok" : "errors");
		err_mark = errors;
	endtask

	task automatic cmd_check_oreg31(input string name, input logic [7:0] code);
		logic [7:0] v;
		run_cmd(name, code);
		read_oreg(31, v);
		check_byte({name, " OREG31"}, code, v);
	endtask

	task automatic sres_pulse();
		@(posedge CLK);
		sres_n <= 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
	endtask

	initial begin
		smpc_time_u set_t;
		smpc_time_u got;
		smpc_time_u exp;
		logic [7:0] o0, o9, v;
		RST_N = 1'b0;
		ce = 1'b1;
		mres_n = 1'b0;
		time_set = 1'b0;
		cs_n = 1'b1;
		rw_n = 1'b1;
		sres_n = 1'b1;
		ac = 4'h0;
		a = 6'h00;
		di = 8'h00;
		repeat (3) @(posedge CLK);
		RST_N <= 1'b1;
		repeat (4) @(posedge CLK);
		mres_n <= 1'b1;
		repeat (2) @(posedge CLK);

		check_level("mres mshres_n", 1'b1, mshres_n);
		check_level("mres mshnmi_n", 1'b1, mshnmi_n);
		check_level("mres sshres_n", 1'b0, sshres_n);
		check_level("mres sshnmi_n", 1'b1, sshnmi_n);
		check_level("mres sysres_n", 1'b1, sysres_n);
		check_level("mres sndres_n", 1'b0, sndres_n);
		check_level("mres cdres_n", 1'b1, cdres_n);
		check_level("mres mirq_n", 1'b1, mirq_n);
		read_reg(`SMPC_ADDR_SF, v);
		check_byte("mres SF", 8'hF0, v);
		end_test("reset_levels");

		cmd_check_oreg31("SSHON", CMD_SSHON);
		check_level("SSHON", 1'b1, sshres_n);
		cmd_check_oreg31("SSHOFF", CMD_SSHOFF);
		check_level("SSHOFF", 1'b0, sshres_n);
		cmd_check_oreg31("SNDON", CMD_SNDON);
		check_level("SNDON", 1'b1, sndres_n);
		cmd_check_oreg31("SNDOFF", CMD_SNDOFF);
		check_level("SNDOFF", 1'b0, sndres_n);
		cmd_check_oreg31("CDOFF", CMD_CDOFF);
		check_level("CDOFF", 1'b0, cdres_n);
		cmd_check_oreg31("CDON", CMD_CDON);
		check_level("CDON", 1'b1, cdres_n);
		run_cmd("unknown", 8'h0D);
		read_oreg(31, v);
		check_byte("unknown OREG31", 8'h0D, v);
		end_test("power_commands");

		@(posedge CLK);
		ac <= 4'($random(seed));
		set_t = rand_time();
		set_time(set_t);
		status_intback(got, o0, o9);
		exp = ref_advance(set_t, 1);
		if (got !== exp) exp = ref_advance(set_t, 0);
		check_time("settime time", exp, got);
		check_byte("settime OREG9", {4'h0, ac}, o9);
		check_level("settime STE", 1'b1, o0[7]);
		check_level("settime MIRQ_N seen", 1'b1, mirq_seen);
		end_test("settime_intback");

		set_t.t = '{year: 16'h1999, wday: 4'd3, month: 4'd2, mday: 8'h28,
			hour: 8'h23, min: 8'h59, sec: 8'h58};
		set_time(set_t);
		repeat (3 * SEC_DIV) @(posedge CLK);
		status_intback(got, o0, o9);
		exp = ref_advance(set_t, 4);
		if (got !== exp) exp = ref_advance(set_t, 3);
		check_time("rollover time", exp, got);
		check_byte("rollover month", 8'h03, {4'h0, got.t.month});
		check_byte("rollover mday", 8'h01, got.t.mday);
		end_test("date_rollover");

		nmi_seen = 1'b0;
		run_cmd("NMIREQ", CMD_NMIREQ);
		check_level("NMIREQ pulse seen", 1'b1, nmi_seen);
		check_level("NMIREQ released", 1'b1, mshnmi_n);
		run_cmd("RESENAB", CMD_RESENAB);
		run_cmd("RESDISA", CMD_RESDISA);
		status_intback(got, o0, o9);
		check_level("RESDISA RESD", 1'b1, o0[6]);
		sres_pulse();
		check_level("disabled mshnmi_n", 1'b1, mshnmi_n);
		check_level("disabled sshnmi_n", 1'b1, sshnmi_n);
		@(posedge CLK);
		sres_n <= 1'b1;
		run_cmd("RESENAB", CMD_RESENAB);
		status_intback(got, o0, o9);
		check_level("RESENAB RESD", 1'b0, o0[6]);
		sres_pulse();
		check_level("enabled mshnmi_n", 1'b0, mshnmi_n);
		check_level("enabled sshnmi_n", 1'b0, sshnmi_n);
		@(posedge CLK);
		sres_n <= 1'b1;
		// Soft reset hold still running, so MSHON has a low NMI to lift
		cmd_check_oreg31("MSHON", CMD_MSHON);
		check_level("MSHON mshres_n", 1'b1, mshres_n);
		check_level("MSHON mshnmi_n", 1'b1, mshnmi_n);
		check_level("MSHON sshnmi_n held", 1'b0, sshnmi_n);
		end_test("nmi_and_soft_reset");

		write_reg(`SMPC_ADDR_IREG0, 8'h01);
		write_reg(`SMPC_ADDR_IREG0 + 7'd4, 8'h00);
		mirq_seen = 1'b0;
		run_cmd("bad INTBACK", CMD_INTBACK);
		check_level("bad INTBACK MIRQ_N seen", 1'b0, mirq_seen);
		end_test("intback_no_key");

		$display("checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* smpc.f */
+incdir+source
source/smpc_pkg.sv
source/smpc_host_regs.sv
source/smpc_cmd_exec.sv
source/smpc_rtc.sv
source/smpc_oreg_file.sv
source/smpc.sv
dv/smpc_sva.sv
dv/smpc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SMPC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f smpc.f --top-module smpc_tb -o smpc_sim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/smpc_sim > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
